//--- src/pg_pkg.sv
/*
 * pg_pkg
 * widths, limits and lookup tables shared by the FM phase generator
 * stages. The note tables stand in for the full increment ROM.
 */
package pg_pkg;

    typedef logic [6:0]  kc_t;
    typedef logic [5:0]  kf_t;
    // octave 13..10, note 9..6, fraction 5..0
    typedef logic [13:0] kcex_t;
    typedef logic [4:0]  keycode_t;
    typedef logic [11:0] phinc_t;
    typedef logic [17:0] base_t;
    typedef logic [19:0] step_t;
    typedef logic [19:0] phase_t;
    typedef logic [9:0]  phase_out_t;
    typedef logic [3:0]  mul_t;
    // bit 2 picks subtraction
    typedef logic [2:0]  dt1_t;
    typedef logic [1:0]  dt2_t;
    typedef logic [2:0]  pms_t;
    // sign in bit 7, magnitude below
    typedef logic [7:0]  pm_t;

    // operator slots served in turn
    localparam int slots = 32;

    // ceiling on the octave-shifted increment
    localparam base_t base_limit = 18'd82976;

    // coarse detune offsets in extended key code units
    localparam kcex_t dt2_offset [4] = '{14'd0, 14'd512, 14'd628, 14'd800};
    // thresholds for the extra note step on dt2 2 and 3
    localparam logic [7:0] dt2_lim [2] = '{8'd75, 8'd95};

    // increment at fraction 0 for each note code
    // unused codes 3, 7, 11 and 15 repeat the next note
    localparam phinc_t note_base [16] = '{
        12'd1299, 12'd1376, 12'd1458, 12'd1545,
        12'd1545, 12'd1637, 12'd1734, 12'd1837,
        12'd1837, 12'd1946, 12'd2062, 12'd2185,
        12'd2185, 12'd2315, 12'd2452, 12'd2598
    };

    // rise up to the next note, scaled by fraction / 64
    localparam logic [7:0] note_slope [16] = '{
        8'd77,  8'd82,  8'd87,  8'd0,
        8'd92,  8'd97,  8'd103, 8'd0,
        8'd109, 8'd116, 8'd123, 8'd0,
        8'd130, 8'd137, 8'd146, 8'd0
    };

    // fine detune mantissa
    localparam logic [4:0] pow2_tbl [8] = '{
        5'd16, 5'd17, 5'd19, 5'd20, 5'd22, 5'd24, 5'd26, 5'd29
    };

    // largest fine detune offset per dt1 amount
    localparam logic [5:0] dt1_limit_tbl [4] = '{6'd8, 6'd8, 6'd16, 6'd22};

endpackage

//--- src/pg_keycode.sv
/*
 * pg_keycode
 * stages I and II of the phase generator. Applies LFO phase modulation
 * with note skipping and saturation, then coarse detune (dt2). Also
 * forms the fine detune key index and the rate key code.
 */
`timescale 1ns/1ps

module pg_keycode (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  pg_pkg::kc_t      kc,
    input  pg_pkg::kf_t      kf,
    input  pg_pkg::pm_t      pm,
    input  pg_pkg::pms_t     pms,
    input  pg_pkg::dt2_t     dt2,
    input  pg_pkg::dt1_t     dt1,
    output pg_pkg::kcex_t    kcex,
    output logic [5:0]       dt1_kf,
    output pg_pkg::keycode_t keycode
);

    logic [8:0]    mod_i;
    logic [14:0]   kc_ext;
    logic [14:0]   mod_ext;
    logic [14:0]   shifted;
    logic [14:0]   skipped;
    logic [12:0]   kc_mod;
    logic [13:0]   dt2_extra;
    pg_pkg::kcex_t kcex_ii;

    // modulation depth from the sensitivity setting
    always_comb begin
        case (pms)
            3'd0:    mod_i = 9'd0;
            3'd1:    mod_i = {7'd0, pm[6:5]};
            3'd2:    mod_i = {6'd0, pm[6:4]};
            3'd3:    mod_i = {5'd0, pm[6:3]};
            3'd4:    mod_i = {4'd0, pm[6:2]};
            3'd5:    mod_i = {3'd0, pm[6:1]};
            3'd6:    mod_i = {1'b0, pm[6:0], 1'b0};
            default: mod_i = {pm[6:0], 2'b00};
        endcase
    end

    assign kc_ext  = {2'b00, kc, kf};
    assign mod_ext = {6'd0, mod_i};
    // negative pm lowers the pitch
    assign shifted = pm[7] ? kc_ext - mod_ext : kc_ext + mod_ext;

    always_comb begin
        // hop over the unused note codes in the direction of travel
        if (shifted[7:6] == 2'b11)
            skipped = pm[7] ? shifted - 15'd64 : shifted + 15'd64;
        else
            skipped = shifted;
        // bit 14 only sets on a borrow
        if (skipped[14])
            kc_mod = 13'd0;
        else if (skipped[13])
            kc_mod = 13'h1fff;
        else
            kc_mod = skipped[12:0];
    end

    always_comb begin
        if (!dt2[1])
            dt2_extra = (kc_mod[7:6] == 2'b11) ? 14'd64 : 14'd0;
        else
            dt2_extra = (kc_mod[7:0] > pg_pkg::dt2_lim[dt2[0]]) ? 14'd64 : 14'd0;
    end

    // stage I
    always_ff @(posedge clk) begin
        if (cen) begin
            kcex_ii <= {1'b0, kc_mod} + pg_pkg::dt2_offset[dt2] + dt2_extra;
        end
    end

    // fine detune index moves with the dt1 amount
    always_comb begin
        case (dt1[1:0])
            2'd1:    dt1_kf = kcex_ii[13:8] - 6'd4;
            2'd2:    dt1_kf = kcex_ii[13:8] + 6'd4;
            2'd3:    dt1_kf = kcex_ii[13:8] + 6'd8;
            default: dt1_kf = kcex_ii[13:8];
        endcase
    end

    // stage II
    always_ff @(posedge clk) begin
        if (cen) begin
            keycode <= kcex_ii[12:8];
        end
    end

    assign kcex = kcex_ii;

endmodule

//--- src/pg_base.sv
/*
 * pg_base
 * stages III and IV. Interpolates the note increment from the base
 * table, shifts it by octave and clamps it. The fine detune controls
 * ride along so they stay aligned with the increment.
 */
`timescale 1ns/1ps

module pg_base (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  pg_pkg::kcex_t kcex,
    input  logic [5:0]    dt1_kf,
    input  pg_pkg::dt1_t  dt1,
    output pg_pkg::base_t base,
    output logic [5:0]    dt1_kf_d,
    output pg_pkg::dt1_t  dt1_d
);

    pg_pkg::kcex_t  kcex_iii;
    logic [5:0]     dt1_kf_iii;
    pg_pkg::dt1_t   dt1_iii;
    logic [3:0]     note;
    logic [13:0]    slope_prod;
    pg_pkg::phinc_t phinc;
    pg_pkg::base_t  base_iv;

    always_ff @(posedge clk) begin
        if (cen) begin
            kcex_iii   <= kcex;
            dt1_kf_iii <= dt1_kf;
            dt1_iii    <= dt1;
        end
    end

    // linear step between neighbouring notes
    assign note       = kcex_iii[9:6];
    assign slope_prod = pg_pkg::note_slope[note] * kcex_iii[5:0];
    assign phinc      = pg_pkg::note_base[note] + {4'd0, slope_prod[13:6]};

    // stage III, octave 2 is the table's own range
    always_ff @(posedge clk) begin
        if (cen) begin
            case (kcex_iii[13:10])
                4'd0:    base_iv <= {8'd0, phinc[11:2]};
                4'd1:    base_iv <= {7'd0, phinc[11:1]};
                4'd2:    base_iv <= {6'd0, phinc};
                4'd3:    base_iv <= {5'd0, phinc, 1'b0};
                4'd4:    base_iv <= {4'd0, phinc, 2'b0};
                4'd5:    base_iv <= {3'd0, phinc, 3'b0};
                4'd6:    base_iv <= {2'd0, phinc, 4'b0};
                4'd7:    base_iv <= {1'b0, phinc, 5'b0};
                4'd8:    base_iv <= {phinc, 6'b0};
                default: base_iv <= '0;
            endcase
            dt1_kf_d <= dt1_kf_iii;
            dt1_d    <= dt1_iii;
        end
    end

    // stage IV
    always_ff @(posedge clk) begin
        if (cen) begin
            base <= (base_iv > pg_pkg::base_limit) ? pg_pkg::base_limit : base_iv;
        end
    end

endmodule

//--- src/pg_detune.sv
/*
 * pg_detune
 * stages IV to VI. Builds the limited fine detune offset from the
 * power-of-two table, applies it with its sign, then scales by the
 * frequency multiplier with mul 0 standing for one half.
 */
`timescale 1ns/1ps

module pg_detune (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  pg_pkg::base_t base,
    input  logic [5:0]    dt1_kf,
    input  pg_pkg::dt1_t  dt1,
    input  pg_pkg::mul_t  mul,
    output pg_pkg::step_t step
);

    logic [4:0]    pow2;
    logic [5:0]    dt1_limit;
    logic [5:0]    dt1_unlimited;
    logic [4:0]    dt1_offset_iv;
    logic [4:0]    dt1_offset_v;
    pg_pkg::dt1_t  dt1_v;
    pg_pkg::step_t base_vi;
    pg_pkg::step_t scaled;

    assign pow2      = pg_pkg::pow2_tbl[dt1_kf[2:0]];
    assign dt1_limit = pg_pkg::dt1_limit_tbl[dt1[1:0]];

    // upper key bits pick how much of the mantissa survives
    always_comb begin
        case (dt1_kf[5:3])
            3'd0:    dt1_unlimited = {5'd0, pow2[4]};
            3'd1:    dt1_unlimited = {4'd0, pow2[4:3]};
            3'd2:    dt1_unlimited = {3'd0, pow2[4:2]};
            3'd3:    dt1_unlimited = {2'd0, pow2[4:1]};
            3'd4:    dt1_unlimited = {1'b0, pow2};
            3'd5:    dt1_unlimited = {pow2, 1'b0};
            default: dt1_unlimited = 6'd0;
        endcase
    end

    assign dt1_offset_iv = (dt1_unlimited > dt1_limit) ? dt1_limit[4:0]
                                                       : dt1_unlimited[4:0];

    // stage IV
    always_ff @(posedge clk) begin
        if (cen) begin
            dt1_offset_v <= dt1_offset_iv;
            dt1_v        <= dt1;
        end
    end

    // stage V, amount 0 means no detune
    always_ff @(posedge clk) begin
        if (cen) begin
            if (dt1_v[1:0] == 2'd0)
                base_vi <= {2'b00, base};
            else if (!dt1_v[2])
                base_vi <= {2'b00, base} + {15'd0, dt1_offset_v};
            else
                base_vi <= {2'b00, base} - {15'd0, dt1_offset_v};
        end
    end

    // wraps at 20 bits for the largest multipliers
    assign scaled = base_vi * mul;

    // stage VI
    always_ff @(posedge clk) begin
        if (cen) begin
            if (mul == 4'd0)
                step <= {1'b0, base_vi[19:1]};
            else
                step <= scaled;
        end
    end

endmodule

//--- src/pg_accum.sv
/*
 * pg_accum
 * stage VII. Per-slot phase accumulator whose state circulates through
 * a delay ring one slot long per entry, plus the pg_rst delay line.
 */
`timescale 1ns/1ps

module pg_accum (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  pg_pkg::step_t      step,
    input  logic               pg_rst,
    output pg_pkg::phase_out_t phase_out
);

    pg_pkg::phase_t ph_viii;
    pg_pkg::phase_t ph_vii;
    // with ph_viii this holds one phase per slot
    pg_pkg::phase_t ring [pg_pkg::slots-1];
    logic [3:0]     rst_dly;

    assign ph_vii = ring[pg_pkg::slots-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ph_viii <= '0;
        end else if (cen) begin
            ph_viii <= rst_dly[3] ? '0 : ph_vii + step;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < pg_pkg::slots - 1; i++) begin
                ring[i] <= '0;
            end
        end else if (cen) begin
            ring[0] <= ph_viii;
            for (int i = 1; i < pg_pkg::slots - 1; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

    // pg_rst enters at stage III and acts at stage VII
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_dly <= '0;
        end else if (cen) begin
            rst_dly <= {rst_dly[2:0], pg_rst};
        end
    end

    assign phase_out = ph_viii[19:10];

endmodule

//--- src/pg_top.sv
/*
 * pg_top
 * phase generator for a four-operator FM synthesizer. Serves 32
 * operator slots in turn, one per cen strobe, and returns the top
 * phase bits plus the rate key code for each slot.
 */
`timescale 1ns/1ps

module pg_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  pg_pkg::kc_t        kc,
    input  pg_pkg::kf_t        kf,
    input  pg_pkg::pm_t        pm,
    input  pg_pkg::pms_t       pms,
    input  pg_pkg::dt2_t       dt2,
    input  pg_pkg::dt1_t       dt1,
    input  pg_pkg::mul_t       mul,
    input  logic               pg_rst,
    output pg_pkg::keycode_t   keycode,
    output pg_pkg::phase_out_t phase_out
);

    pg_pkg::kcex_t kcex;
    logic [5:0]    dt1_kf;
    pg_pkg::base_t base;
    logic [5:0]    dt1_kf_d;
    pg_pkg::dt1_t  dt1_d;
    pg_pkg::step_t step;

    pg_keycode pg_keycode_inst (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .kc      (kc),
        .kf      (kf),
        .pm      (pm),
        .pms     (pms),
        .dt2     (dt2),
        .dt1     (dt1),
        .kcex    (kcex),
        .dt1_kf  (dt1_kf),
        .keycode (keycode)
    );

    pg_base pg_base_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .kcex     (kcex),
        .dt1_kf   (dt1_kf),
        .dt1      (dt1),
        .base     (base),
        .dt1_kf_d (dt1_kf_d),
        .dt1_d    (dt1_d)
    );

    pg_detune pg_detune_inst (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .base   (base),
        .dt1_kf (dt1_kf_d),
        .dt1    (dt1_d),
        .mul    (mul),
        .step   (step)
    );

    pg_accum pg_accum_inst (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .step      (step),
        .pg_rst    (pg_rst),
        .phase_out (phase_out)
    );

endmodule

//--- dv/pg_checker.sv
/*
 * pg_checker
 * concurrent assertions on the phase generator top level: reset
 * value, hold while cen is low and the delayed pg_rst clear
 */
`timescale 1ns/1ps

module pg_checker (
    input logic               clk,
    input logic               rst,
    input logic               cen,
    input logic               pg_rst,
    input pg_pkg::phase_out_t phase_out
);

    // pg_rst history in cen cycles
    logic [3:0] pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= '0;
        end else if (cen) begin
            pend <= {pend[2:0], pg_rst};
        end
    end

    reset_zero: assert property (@(posedge clk) rst |-> phase_out == '0)
        else $error("phase_out not zero during reset");

    hold_when_idle: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(phase_out))
        else $error("phase_out moved while cen was low");

    // pg_rst reaches the accumulator four cen cycles after it is sampled
    clear_on_pg_rst: assert property (@(posedge clk) disable iff (rst)
        (cen && pend[3]) |=> phase_out == '0)
        else $error("phase_out not cleared after pg_rst");

endmodule

bind pg_top pg_checker pg_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .pg_rst    (pg_rst),
    .phase_out (phase_out)
);

//--- dv/pg_tb.sv
/*
 * pg_tb
 * directed testbench for the FM phase generator. A reference model
 * computes the step and key code per parameter set, and the phase of
 * each slot is followed across 32-cycle rounds.
 */
`timescale 1ns/1ps

module pg_tb;

    logic               clk;
    logic               rst;
    logic               cen;
    pg_pkg::kc_t        kc;
    pg_pkg::kf_t        kf;
    pg_pkg::pm_t        pm;
    pg_pkg::pms_t       pms;
    pg_pkg::dt2_t       dt2;
    pg_pkg::dt1_t       dt1;
    pg_pkg::mul_t       mul;
    logic               pg_rst;
    pg_pkg::keycode_t   keycode;
    pg_pkg::phase_out_t phase_out;

    int          errors;
    int          checks;
    logic        strobe;
    logic [31:0] rand_state;

    pg_top pg_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .kc        (kc),
        .kf        (kf),
        .pm        (pm),
        .pms       (pms),
        .dt2       (dt2),
        .dt1       (dt1),
        .mul       (mul),
        .pg_rst    (pg_rst),
        .keycode   (keycode),
        .phase_out (phase_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // extended key code after modulation and coarse detune
    function automatic int model_kcex(int c, int f, int p, int s, int d2);
        int mag;
        int md;
        int v;
        int extra;
        mag = p & 127;
        if (s == 0)
            md = 0;
        else if (s <= 5)
            md = mag >> (6 - s);
        else if (s == 6)
            md = mag << 1;
        else
            md = mag << 2;
        v = c * 64 + f;
        v = (p >= 128) ? v - md : v + md;
        if (((v >> 6) & 3) == 3)
            v = (p >= 128) ? v - 64 : v + 64;
        if (v < 0)
            v = 0;
        else if (v > 8191)
            v = 8191;
        if (d2 < 2)
            extra = (((v >> 6) & 3) == 3) ? 64 : 0;
        else
            extra = ((v & 255) > int'(pg_pkg::dt2_lim[d2 & 1])) ? 64 : 0;
        return (v + int'(pg_pkg::dt2_offset[d2]) + extra) & 16'h3fff;
    endfunction

    function automatic int model_step(int kx, int d1, int m);
        int note;
        int oct;
        int phinc;
        int b;
        int dkf;
        int sh;
        int off;
        int lim;
        longint v;
        note  = (kx >> 6) & 15;
        oct   = (kx >> 10) & 15;
        phinc = int'(pg_pkg::note_base[note])
              + ((int'(pg_pkg::note_slope[note]) * (kx & 63)) >> 6);
        if (oct == 0)
            b = phinc >> 2;
        else if (oct == 1)
            b = phinc >> 1;
        else if (oct <= 8)
            b = phinc << (oct - 2);
        else
            b = 0;
        if (b > int'(pg_pkg::base_limit))
            b = int'(pg_pkg::base_limit);
        dkf = kx >> 8;
        case (d1 & 3)
            1: dkf = dkf - 4;
            2: dkf = dkf + 4;
            3: dkf = dkf + 8;
            default: dkf = dkf;
        endcase
        dkf = dkf & 63;
        sh  = dkf >> 3;
        off = int'(pg_pkg::pow2_tbl[dkf & 7]);
        if (sh <= 4)
            off = off >> (4 - sh);
        else if (sh == 5)
            off = off << 1;
        else
            off = 0;
        lim = int'(pg_pkg::dt1_limit_tbl[d1 & 3]);
        if (off > lim)
            off = lim;
        v = b;
        if ((d1 & 3) != 0)
            v = (d1 & 4) ? v - off : v + off;
        v = v & 20'hfffff;
        if (m == 0)
            v = v >> 1;
        else
            v = (v * m) & 20'hfffff;
        return int'(v);
    endfunction

    task automatic check_phase(input pg_pkg::phase_out_t expected,
                               input pg_pkg::phase_out_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t phase_out expected %h actual %h",
                     $time, expected, actual);
        end
    endtask

    task automatic check_keycode(input pg_pkg::keycode_t expected,
                                 input pg_pkg::keycode_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t keycode expected %h actual %h",
                     $time, expected, actual);
        end
    endtask

    // waits for n cen cycles, ending just after a falling edge
    task automatic step_cycles(input int n);
        int count;
        int guard;
        count = 0;
        guard = 0;
        while (count < n && guard < 4 * n + 8) begin
            @(posedge clk);
            if (cen)
                count++;
            @(negedge clk);
            if (strobe)
                cen = ~cen;
            guard++;
        end
        if (count < n) begin
            errors++;
            $display("timed out at %0t waiting for %0d cen cycles", $time, n);
        end
    endtask

    // one parameter set on all slots, phase cleared then followed
    task automatic run_case(input int c, input int f, input int p, input int s,
                            input int d2, input int d1, input int m);
        int kx;
        int st;
        pg_pkg::phase_t acc;
        kx  = model_kcex(c, f, p, s, d2);
        st  = model_step(kx, d1, m);
        kc  = pg_pkg::kc_t'(c);
        kf  = pg_pkg::kf_t'(f);
        pm  = pg_pkg::pm_t'(p);
        pms = pg_pkg::pms_t'(s);
        dt2 = pg_pkg::dt2_t'(d2);
        dt1 = pg_pkg::dt1_t'(d1);
        mul = pg_pkg::mul_t'(m);
        step_cycles(2);
        check_keycode(pg_pkg::keycode_t'(kx >> 8), keycode);
        pg_rst = 1'b1;
        step_cycles(8);
        check_phase('0, phase_out);
        step_cycles(32);
        pg_rst = 1'b0;
        step_cycles(5);
        acc = '0;
        for (int k = 0; k < 3; k++) begin
            acc = acc + pg_pkg::step_t'(st);
            check_phase(acc[19:10], phase_out);
            if (k < 2)
                step_cycles(32);
        end
    endtask

    task automatic test_basic();
        run_case(7'h4a, 0, 0, 0, 0, 0, 1);
        run_case(7'h21, 17, 0, 0, 0, 0, 1);
    endtask

    task automatic test_mul();
        run_case(7'h4a, 5, 0, 0, 0, 0, 0);
        for (int i = 0; i < 4; i++) begin
            run_case(next_rand() % 128, next_rand() % 64, 0, 0, 0, 0,
                     1 + next_rand() % 15);
        end
    endtask

    task automatic test_fine_detune();
        for (int d = 1; d < 8; d++) begin
            if (d != 4)
                run_case(next_rand() % 128, next_rand() % 64, 0, 0, 0, d, 1);
        end
        // top octaves hit the base clamp
        run_case(7'h7e, 63, 0, 0, 0, 3, 1);
        run_case(7'h7e, 63, 0, 0, 3, 7, 2);
    endtask

    task automatic test_coarse_detune();
        for (int d = 0; d < 4; d++) begin
            run_case(next_rand() % 112, next_rand() % 64, 0, 0, d,
                     next_rand() % 8, 1);
        end
    endtask

    task automatic test_phase_mod();
        for (int s = 0; s < 8; s++) begin
            run_case(7'h32, 60, 8'h55, s, 0, 0, 1);
            run_case(7'h34, 2, 8'hd5, s, 0, 0, 1);
        end
        // saturation at both ends
        run_case(0, 0, 8'hff, 7, 0, 0, 1);
        run_case(7'h7e, 63, 8'h7f, 7, 0, 0, 1);
    endtask

    task automatic test_reset_and_hold();
        pg_pkg::phase_out_t held;
        strobe = 1'b1;
        run_case(7'h45, 33, 0, 0, 1, 2, 3);
        strobe = 1'b0;
        cen    = 1'b1;
        step_cycles(3);
        held = phase_out;
        cen  = 1'b0;
        // longer than one round, so a running ring would reach the next step
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            check_phase(held, phase_out);
        end
        cen = 1'b1;
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        strobe     = 1'b0;
        rand_state = 32'd95;
        rst        = 1'b1;
        cen        = 1'b1;
        kc         = '0;
        kf         = '0;
        pm         = '0;
        pms        = '0;
        dt2        = '0;
        dt1        = '0;
        mul        = 4'd1;
        pg_rst     = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_phase('0, phase_out);
        test_basic();
        test_mul();
        test_fine_detune();
        test_coarse_detune();
        test_phase_mod();
        test_reset_and_hold();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/pg_pkg.sv
src/pg_keycode.sv
src/pg_base.sv
src/pg_detune.sv
src/pg_accum.sv
src/pg_top.sv
dv/pg_checker.sv
dv/pg_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the phase generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pg_tb -f verilog.f -o pg_sim \
    && ./obj_dir/pg_sim | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
